// ==== data_memory.sv ====
`timescale 1ns/10ps
`include "pipe3_cpu_macros.svh"

module data_memory import pipe3_cpu_pkg::*; #(
  parameter int DEPTH = `DMEM_DEPTH
) (
  input  logic  clk_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  logic  we_i,
  output data_t rdata_o
);

  localparam int IDX_W = $clog2(DEPTH);

  data_t            mem [DEPTH] = '{default: '0};
  logic [IDX_W-1:0] idx;

  assign idx = addr_i[IDX_W-1:0]; // Word address, upper bits wrap.

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[idx] <= wdata_i;
    end
  end

  assign rdata_o = mem[idx];

endmodule : data_memory

// ==== decode_stage.sv ====
`timescale 1ns/10ps
`include "pipe3_cpu_macros.svh"

module decode_stage import pipe3_cpu_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         valid_i,
  input  logic         is_jump_i,
  input  logic         branch_taken_i,
  input  addr_t        pc_i,
  input  data_t        reg_a_data_i,
  input  data_t        reg_b_data_i,
  input  instruction_t instruction_i,
  output logic         alu_valid_o,
  output data_t        offset_sign_extend_o,
  output reg_idx_t     reg_a_o,
  output logic         reg_wr_en_o,
  output reg_idx_t     wr_reg_o,
  output opcode_e      instr_opcode_o,
  output addr_t        branch_offset_o,
  output addr_t        alu_pc_o,
  output data_t        alu_reg_a_data_o,
  output data_t        alu_reg_b_data_o,
  output addr_t        debug_alu_pc_o,
  output instruction_t debug_alu_instr_o
);

  localparam int OFFSET_LSB = `OPCODE_WIDTH + 2 * `REGISTER_WIDTH;
  localparam int OFFSET_W   = `INSTR_WIDTH - OFFSET_LSB;
  localparam int BR_OFF_W   = $bits(instruction_i.free) + `REGISTER_WIDTH;

  logic  is_store;
  logic  is_branch;
  logic  reg_wr_en_d;
  data_t offset_sign_extend_d;
  addr_t branch_offset_d;

  // ******************************************************************
  // Field decode
  // ******************************************************************

  assign is_store  = instruction_i.opcode == SW;
  assign is_branch = instruction_i.opcode inside {BEQ, BNE, BLT, BGE};

  assign reg_a_o = is_store ? instruction_i.rd : instruction_i.ra; // Store data comes from rd.

  assign reg_wr_en_d = ~is_store & ~is_branch & (instruction_i.opcode != JMP);

  assign offset_sign_extend_d = {{(`DATA_WIDTH-OFFSET_W){instruction_i[`INSTR_WIDTH-1]}},
                                 instruction_i[`INSTR_WIDTH-1:OFFSET_LSB]};

  // Branch offset is free joined to rd.
  assign branch_offset_d = {{(`ADDR_WIDTH-BR_OFF_W){instruction_i.free[$high(instruction_i.free)]}},
                            instruction_i.free, instruction_i.rd};

  // ******************************************************************
  // Decode to execute register
  // ******************************************************************

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alu_valid_o <= 1'b0;
      reg_wr_en_o <= 1'b0;
    end else begin
      alu_valid_o <= valid_i & ~is_jump_i & ~branch_taken_i; // Squash behind a redirect.
      reg_wr_en_o <= reg_wr_en_d;
    end
  end

  always_ff @(posedge clk_i) begin
    offset_sign_extend_o <= offset_sign_extend_d;
    wr_reg_o             <= instruction_i.rd;
    instr_opcode_o       <= instruction_i.opcode;
    branch_offset_o      <= branch_offset_d;
    alu_pc_o             <= pc_i;
    alu_reg_a_data_o     <= reg_a_data_i;
    alu_reg_b_data_o     <= reg_b_data_i;
    debug_alu_pc_o       <= pc_i;
    debug_alu_instr_o    <= instruction_i;
  end

  // The redirect comes from execute in the same cycle.
  squash_after_redirect: assert property (@(posedge clk_i) disable iff (!rst_i)
    (is_jump_i | branch_taken_i) |=> !(is_jump_i | branch_taken_i))
    else $error("Instruction behind a redirect reached execute.");

endmodule : decode_stage

// ==== execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage import pipe3_cpu_pkg::*; (
  input  exec_in_t  exec_i,
  input  data_t     dmem_rdata_i,
  output addr_t     dmem_addr_o,
  output data_t     dmem_wdata_o,
  output logic      dmem_we_o,
  output wb_t       wb_o,
  output redirect_t redirect_o
);

  data_t alu_result;
  data_t wb_data;
  logic  is_load;
  logic  is_store;
  logic  is_branch;
  logic  cond_true;
  logic  equal;
  logic  less_unsigned;
  logic  less_signed;
  addr_t load_addr;
  addr_t store_addr;

  // ******************************************************************
  // ALU
  // ******************************************************************

  always_comb begin
    case (exec_i.opcode)
      ADD:     alu_result = exec_i.a_data + exec_i.b_data;
      SUB:     alu_result = exec_i.a_data - exec_i.b_data;
      AND:     alu_result = exec_i.a_data & exec_i.b_data;
      OR:      alu_result = exec_i.a_data | exec_i.b_data;
      XOR:     alu_result = exec_i.a_data ^ exec_i.b_data;
      ADDI:    alu_result = exec_i.a_data + exec_i.offset;
      default: alu_result = '0;
    endcase
  end

  // ******************************************************************
  // Branch resolution
  // ******************************************************************

  assign equal         = exec_i.a_data == exec_i.b_data;
  assign less_unsigned = exec_i.a_data < exec_i.b_data;
  // With differing signs the negative operand is the smaller one.
  assign less_signed   = (exec_i.a_data[$high(exec_i.a_data)] != exec_i.b_data[$high(exec_i.b_data)])
                         ? exec_i.a_data[$high(exec_i.a_data)] : less_unsigned;

  always_comb begin
    case (exec_i.opcode)
      BEQ:     cond_true = equal;
      BNE:     cond_true = ~equal;
      BLT:     cond_true = less_signed;
      BGE:     cond_true = ~less_signed;
      default: cond_true = 1'b0;
    endcase
  end

  assign is_branch = exec_i.opcode inside {BEQ, BNE, BLT, BGE};

  assign redirect_o = '{is_jump:      exec_i.valid & (exec_i.opcode == JMP),
                        branch_taken: exec_i.valid & is_branch & cond_true,
                        target:       exec_i.pc + exec_i.branch_offset};

  // ******************************************************************
  // Memory access and writeback
  // ******************************************************************

  assign is_load    = exec_i.opcode == LW;
  assign is_store   = exec_i.opcode == SW;
  assign load_addr  = exec_i.a_data + exec_i.offset;
  assign store_addr = exec_i.offset; // Stores use the offset alone.

  assign dmem_addr_o  = is_store ? store_addr : load_addr;
  assign dmem_wdata_o = exec_i.a_data; // Decode put rd on port A.
  assign dmem_we_o    = exec_i.valid & is_store;

  assign wb_data = is_load ? dmem_rdata_i : alu_result;

  assign wb_o = '{valid:  exec_i.valid & exec_i.reg_wr_en & (exec_i.wr_reg != '0),
                  wr_reg: exec_i.wr_reg,
                  data:   wb_data};

  always_comb begin
    no_wb_on_control: assert final ((wb_o.valid !== 1'b1) ||
                                    !(exec_i.opcode inside {BEQ, BNE, BLT, BGE, JMP}))
      else $error("Writeback strobe raised by a branch or jump.");
    store_wb_exclusive: assert final (!((dmem_we_o === 1'b1) && (wb_o.valid === 1'b1)))
      else $error("Store strobe and writeback strobe are high together.");
  end

endmodule : execute_stage

// ==== fetch_stage.sv ====
`timescale 1ns/10ps
`include "pipe3_cpu_macros.svh"

module fetch_stage import pipe3_cpu_pkg::*; #(
  parameter int DEPTH = `IMEM_DEPTH
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         prog_we_i,
  input  addr_t        prog_addr_i,
  input  instruction_t prog_data_i,
  input  redirect_t    redirect_i,
  output fetch_out_t   fetch_o
);

  localparam int IDX_W = $clog2(DEPTH);

  instruction_t imem [DEPTH];

  addr_t        pc_q;
  addr_t        fetch_addr;
  logic         take_redirect;
  logic         valid_q;
  addr_t        fetch_pc_q;
  instruction_t instr_q;

  // ******************************************************************
  // Program load port
  // ******************************************************************

  always_ff @(posedge clk_i) begin
    if (prog_we_i) begin
      imem[prog_addr_i[IDX_W-1:0]] <= prog_data_i;
    end
  end

  // ******************************************************************
  // PC and fetch register
  // ******************************************************************

  assign take_redirect = redirect_i.is_jump | redirect_i.branch_taken;
  assign fetch_addr    = take_redirect ? redirect_i.target : pc_q; // Target is fetched at once.

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q    <= '0;
      valid_q <= 1'b0;
    end else begin
      pc_q    <= fetch_addr + addr_t'(1); // The pc counts in words.
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    fetch_pc_q <= fetch_addr;
    instr_q    <= imem[fetch_addr[IDX_W-1:0]];
  end

  assign fetch_o = '{valid: valid_q, pc: fetch_pc_q, instr: instr_q};

  prog_addr_in_range: assert property (@(posedge clk_i) prog_we_i |-> prog_addr_i < DEPTH)
    else $error("Program load address %0d is beyond the instruction memory.", prog_addr_i);

endmodule : fetch_stage

// ==== pipe3_cpu.f ====
+incdir+.
pipe3_cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
data_memory.sv
pipe3_cpu.sv
tb_pipe3_cpu.sv

// ==== pipe3_cpu.sv ====
`timescale 1ns/10ps
`include "pipe3_cpu_macros.svh"

module pipe3_cpu import pipe3_cpu_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         prog_we_i,
  input  addr_t        prog_addr_i,
  input  instruction_t prog_data_i,
  output logic         wb_valid_o,
  output reg_idx_t     wb_reg_o,
  output data_t        wb_data_o,
  output logic         st_valid_o,
  output addr_t        st_addr_o,
  output data_t        st_data_o,
  output addr_t        dbg_pc_o,
  output instruction_t dbg_instr_o
);

  fetch_out_t    fetch_q;
  redirect_t     redirect;
  wb_t           wb;
  reg_idx_t      rd_a_idx;
  data_t         rd_a_data;
  data_t         rd_b_data;
  addr_t         dmem_addr;
  data_t         dmem_wdata;
  data_t         dmem_rdata;
  logic          dmem_we;
  wire exec_in_t exec_in;

  // ******************************************************************
  // Pipeline stages
  // ******************************************************************

  fetch_stage #(.DEPTH(`IMEM_DEPTH)) u_fetch (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .redirect_i  (redirect),
    .fetch_o     (fetch_q)
  );

  decode_stage u_decode (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .valid_i              (fetch_q.valid),
    .is_jump_i            (redirect.is_jump),
    .branch_taken_i       (redirect.branch_taken),
    .pc_i                 (fetch_q.pc),
    .reg_a_data_i         (rd_a_data),
    .reg_b_data_i         (rd_b_data),
    .instruction_i        (fetch_q.instr),
    .alu_valid_o          (exec_in.valid),
    .offset_sign_extend_o (exec_in.offset),
    .reg_a_o              (rd_a_idx),
    .reg_wr_en_o          (exec_in.reg_wr_en),
    .wr_reg_o             (exec_in.wr_reg),
    .instr_opcode_o       (exec_in.opcode),
    .branch_offset_o      (exec_in.branch_offset),
    .alu_pc_o             (exec_in.pc),
    .alu_reg_a_data_o     (exec_in.a_data),
    .alu_reg_b_data_o     (exec_in.b_data),
    .debug_alu_pc_o       (dbg_pc_o),
    .debug_alu_instr_o    (dbg_instr_o)
  );

  register_file u_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_a_idx_i  (rd_a_idx),
    .rd_b_idx_i  (fetch_q.instr.rb), // Port B always reads rb.
    .rd_a_data_o (rd_a_data),
    .rd_b_data_o (rd_b_data),
    .wb_i        (wb)
  );

  execute_stage u_execute (
    .exec_i       (exec_in),
    .dmem_rdata_i (dmem_rdata),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_we_o    (dmem_we),
    .wb_o         (wb),
    .redirect_o   (redirect)
  );

  data_memory #(.DEPTH(`DMEM_DEPTH)) u_dmem (
    .clk_i   (clk_i),
    .addr_i  (dmem_addr),
    .wdata_i (dmem_wdata),
    .we_i    (dmem_we),
    .rdata_o (dmem_rdata)
  );

  // Trace strobes for the testbench.
  assign wb_valid_o = wb.valid;
  assign wb_reg_o   = wb.wr_reg;
  assign wb_data_o  = wb.data;
  assign st_valid_o = dmem_we;
  assign st_addr_o  = dmem_addr;
  assign st_data_o  = dmem_wdata;

endmodule : pipe3_cpu

// ==== pipe3_cpu_macros.svh ====
`ifndef PIPE3_CPU_MACROS_SVH
`define PIPE3_CPU_MACROS_SVH

// Widths fixed by the instruction format.
`define DATA_WIDTH     32
`define ADDR_WIDTH     32
`define REGISTER_WIDTH 5
`define OPCODE_WIDTH   4
`define INSTR_WIDTH    32

// Memory depths in words.
`define IMEM_DEPTH     256
`define DMEM_DEPTH     256

`endif

// ==== pipe3_cpu_pkg.sv ====
`include "pipe3_cpu_macros.svh"

package pipe3_cpu_pkg;

  typedef logic [`DATA_WIDTH-1:0]     data_t;
  typedef logic [`ADDR_WIDTH-1:0]     addr_t;
  typedef logic [`REGISTER_WIDTH-1:0] reg_idx_t;

  // ADD must stay at zero so that an all-zero word is a no-op.
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    ADDI = 4'd5,
    LW   = 4'd6,
    SW   = 4'd7,
    BEQ  = 4'd8,
    BNE  = 4'd9,
    BLT  = 4'd10,
    BGE  = 4'd11,
    JMP  = 4'd12
  } opcode_e;

  typedef struct packed {
    logic [`INSTR_WIDTH-3*`REGISTER_WIDTH-`OPCODE_WIDTH-1:0] free;
    reg_idx_t rb;
    reg_idx_t rd;
    reg_idx_t ra;
    opcode_e  opcode;
  } instruction_t;

  typedef struct packed {
    logic         valid;
    addr_t        pc;
    instruction_t instr;
  } fetch_out_t;

  typedef struct packed {
    logic     valid;
    logic     reg_wr_en;
    data_t    offset;
    reg_idx_t wr_reg;
    opcode_e  opcode;
    addr_t    branch_offset;
    addr_t    pc;
    data_t    a_data;
    data_t    b_data;
  } exec_in_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t wr_reg;
    data_t    data;
  } wb_t;

  typedef struct packed {
    logic  is_jump;
    logic  branch_taken;
    addr_t target;
  } redirect_t;

endpackage : pipe3_cpu_pkg

// ==== register_file.sv ====
`timescale 1ns/10ps

module register_file import pipe3_cpu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_idx_t rd_a_idx_i,
  input  reg_idx_t rd_b_idx_i,
  output data_t    rd_a_data_o,
  output data_t    rd_b_data_o,
  input  wb_t      wb_i
);

  data_t regs [2**$bits(reg_idx_t)];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < $size(regs); i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid && (wb_i.wr_reg != '0)) begin
      regs[wb_i.wr_reg] <= wb_i.data;
    end
  end

  // Write-through so the next instruction sees the result in decode.
  assign rd_a_data_o = (rd_a_idx_i == '0) ? '0 :
                       (wb_i.valid && (wb_i.wr_reg == rd_a_idx_i)) ? wb_i.data :
                       regs[rd_a_idx_i];

  assign rd_b_data_o = (rd_b_idx_i == '0) ? '0 :
                       (wb_i.valid && (wb_i.wr_reg == rd_b_idx_i)) ? wb_i.data :
                       regs[rd_b_idx_i];

endmodule : register_file

// ==== tb_pipe3_cpu.sv ====
`timescale 1ns/10ps
`include "pipe3_cpu_macros.svh"

module tb_pipe3_cpu import pipe3_cpu_pkg::*; ();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 3;
  localparam int WAIT_LIMIT   = 200;
  localparam int MODEL_STEPS  = 500;
  localparam int TEST_CYCLES  = 250;
  localparam int NUM_TESTS    = 5;
  localparam int MARGIN       = 2;

  logic         clk_i;
  logic         rst_i;
  logic         prog_we_i;
  addr_t        prog_addr;
  instruction_t prog_data;
  logic         wb_valid_o;
  reg_idx_t     wb_reg_o;
  data_t        wb_data_o;
  logic         st_valid_o;
  addr_t        st_addr_o;
  data_t        st_data_o;
  addr_t        dbg_pc;
  instruction_t dbg_instr;

  instruction_t prog_q [$];
  logic         exp_kind [$]; // 0 is a register write, 1 is a store.
  data_t        exp_idx [$];
  data_t        exp_data [$];
  data_t        exp_pc [$];
  data_t        model_regs [32];
  data_t        model_dmem [`DMEM_DEPTH] = '{default: '0};
  logic [15:0]  lfsr_state;
  logic         monitor_on;

  pipe3_cpu uut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr),
    .prog_data_i (prog_data),
    .wb_valid_o  (wb_valid_o),
    .wb_reg_o    (wb_reg_o),
    .wb_data_o   (wb_data_o),
    .st_valid_o  (st_valid_o),
    .st_addr_o   (st_addr_o),
    .st_data_o   (st_data_o),
    .dbg_pc_o    (dbg_pc),
    .dbg_instr_o (dbg_instr)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ******************************************************************
  // Error reporting and random numbers
  // ******************************************************************

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH at time %0t: %s is 0x%08h, expected 0x%08h",
                          $time, name, actual, expected));
    end
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]}; // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic random_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  // ******************************************************************
  // Instruction encoding
  // ******************************************************************

  function automatic instruction_t alu_word(input opcode_e op, input reg_idx_t rd,
                                            input reg_idx_t ra, input reg_idx_t rb);
    return instruction_t'({13'd0, rb, rd, ra, op});
  endfunction

  function automatic instruction_t imm_word(input opcode_e op, input reg_idx_t rd,
                                            input reg_idx_t ra, input logic [17:0] off);
    return instruction_t'({off, rd, ra, op});
  endfunction

  // The branch offset is split over the free field and rd.
  function automatic instruction_t branch_word(input opcode_e op, input reg_idx_t ra,
                                               input reg_idx_t rb, input logic [17:0] boff);
    return instruction_t'({boff[17:5], rb, boff[4:0], ra, op});
  endfunction

  task automatic append_instr(input instruction_t word);
    prog_q.push_back(word);
  endtask

  task automatic close_program();
    append_instr(branch_word(JMP, 5'd0, 5'd0, 18'd0)); // Jump to itself ends the program.
  endtask

  // ******************************************************************
  // Instruction-set model
  // ******************************************************************

  task automatic write_model_reg(input reg_idx_t rd, input data_t value);
    if (rd != '0) begin
      model_regs[rd] = value;
      exp_kind.push_back(1'b0);
      exp_idx.push_back(data_t'(rd));
      exp_data.push_back(value);
    end
  endtask

  task automatic run_model();
    instruction_t ins;
    data_t        pc;
    data_t        next_pc;
    data_t        a;
    data_t        b;
    data_t        off;
    data_t        boff;
    logic         taken;
    logic         done;
    int           steps;
    int           queued;
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    while (!done && steps < MODEL_STEPS) begin
      if (pc >= prog_q.size()) begin
        abort_run($sformatf("Model ran past the end of the program at pc %0d.", pc));
      end else begin
        ins     = prog_q[pc];
        a       = model_regs[ins.ra];
        b       = model_regs[ins.rb];
        off     = {{14{ins[31]}}, ins[31:14]};
        boff    = {{14{ins.free[12]}}, ins.free, ins.rd};
        next_pc = pc + 1;
        taken   = 1'b0;
        queued  = exp_kind.size();
        case (ins.opcode)
          ADD:  write_model_reg(ins.rd, a + b);
          SUB:  write_model_reg(ins.rd, a - b);
          AND:  write_model_reg(ins.rd, a & b);
          OR:   write_model_reg(ins.rd, a | b);
          XOR:  write_model_reg(ins.rd, a ^ b);
          ADDI: write_model_reg(ins.rd, a + off);
          LW:   write_model_reg(ins.rd, model_dmem[(a + off) % `DMEM_DEPTH]);
          SW: begin
            model_dmem[off % `DMEM_DEPTH] = model_regs[ins.rd];
            exp_kind.push_back(1'b1);
            exp_idx.push_back(off);
            exp_data.push_back(model_regs[ins.rd]);
          end
          BEQ:  taken = (a == b);
          BNE:  taken = (a != b);
          BLT:  taken = ($signed(a) < $signed(b));
          BGE:  taken = ($signed(a) >= $signed(b));
          JMP: begin
            taken = 1'b1;
            done  = (boff == '0);
          end
          default: abort_run("Model met an opcode outside the instruction set.");
        endcase
        if (exp_kind.size() > queued) begin
          exp_pc.push_back(pc); // The strobe comes with this instruction on the trace ports.
        end
        pc    = taken ? pc + boff : next_pc;
        steps = steps + 1;
      end
    end
    if (!done) begin
      abort_run("Model did not reach the end of the program.");
    end
  endtask

  // ******************************************************************
  // Monitor of the writeback and store strobes
  // ******************************************************************

  task automatic compare_event(input logic kind, input data_t idx, input data_t data);
    logic  ek;
    data_t ei;
    data_t ed;
    data_t ep;
    if (exp_kind.size() == 0) begin
      abort_run($sformatf("Unexpected strobe at time %0t after the last expected one.", $time));
    end else begin
      ek = exp_kind.pop_front();
      ei = exp_idx.pop_front();
      ed = exp_data.pop_front();
      ep = exp_pc.pop_front();
      check("strobe kind (0 wb_valid_o, 1 st_valid_o)", 32'(kind), 32'(ek));
      check(kind ? "st_addr_o" : "wb_reg_o", idx, ei);
      check(kind ? "st_data_o" : "wb_data_o", data, ed);
      check("dbg_pc_o", dbg_pc, ep);
      check("dbg_instr_o", dbg_instr, prog_q[ep]);
    end
  endtask

  always @(negedge clk_i) begin
    if (monitor_on) begin
      if (wb_valid_o === 1'b1 && st_valid_o === 1'b1) begin
        abort_run("Writeback and store strobes are high in the same cycle.");
      end else if (wb_valid_o === 1'b1 && wb_reg_o == '0) begin
        abort_run("A write to register 0 appeared on the writeback port.");
      end else if (wb_valid_o === 1'b1) begin
        compare_event(1'b0, data_t'(wb_reg_o), wb_data_o);
      end else if (st_valid_o === 1'b1) begin
        compare_event(1'b1, st_addr_o, st_data_o);
      end else if (wb_valid_o !== 1'b0 || st_valid_o !== 1'b0) begin
        abort_run("A strobe is unknown while the core runs.");
      end
    end
  end

  // ******************************************************************
  // Program load and run
  // ******************************************************************

  task automatic run_program(input string name);
    int waited;
    @(posedge clk_i);
    rst_i <= 1'b0;
    foreach (prog_q[i]) begin
      @(posedge clk_i);
      prog_we_i <= 1'b1;
      prog_addr <= addr_t'(i);
      prog_data <= prog_q[i];
    end
    @(posedge clk_i);
    prog_we_i <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    run_model();
    monitor_on = 1'b1;
    rst_i <= 1'b1;
    waited = 0;
    while (exp_kind.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_kind.size() != 0) begin
      abort_run($sformatf("%s: %0d expected strobes never appeared.", name, exp_kind.size()));
    end else begin
      repeat (6) @(posedge clk_i); // Catch strobes beyond the model's end.
      $display("%s done", name);
    end
  endtask

  // ******************************************************************
  // Directed tests
  // ******************************************************************

  task automatic chain_alu_ops();
    prog_q.delete();
    append_instr(imm_word(ADDI, 5'd1, 5'd0, 18'd100));
    append_instr(imm_word(ADDI, 5'd2, 5'd1, -18'sd7));
    append_instr(alu_word(ADD, 5'd3, 5'd2, 5'd1));
    append_instr(alu_word(SUB, 5'd4, 5'd2, 5'd3)); // Goes negative.
    append_instr(alu_word(AND, 5'd5, 5'd4, 5'd3));
    append_instr(alu_word(OR, 5'd6, 5'd5, 5'd2));
    append_instr(alu_word(XOR, 5'd7, 5'd6, 5'd4));
    append_instr(alu_word(ADD, 5'd8, 5'd7, 5'd7));
    close_program();
    run_program("ALU chain");
  endtask

  task automatic store_then_load();
    logic [31:0] imm;
    prog_q.delete();
    random_bits(18, imm);
    append_instr(imm_word(ADDI, 5'd1, 5'd0, imm[17:0]));
    append_instr(imm_word(SW, 5'd1, 5'd0, 18'd20));
    append_instr(imm_word(LW, 5'd3, 5'd0, 18'd20));
    append_instr(imm_word(ADDI, 5'd2, 5'd0, 18'd17));
    append_instr(imm_word(SW, 5'd2, 5'd0, 18'd200));
    append_instr(imm_word(LW, 5'd4, 5'd2, 18'd3));
    append_instr(imm_word(LW, 5'd5, 5'd2, 18'd183));
    close_program();
    run_program("store and load");
  endtask

  task automatic branch_conditions();
    prog_q.delete();
    append_instr(imm_word(ADDI, 5'd1, 5'd0, -18'sd5));
    append_instr(imm_word(ADDI, 5'd2, 5'd0, -18'sd3));
    append_instr(branch_word(BEQ, 5'd1, 5'd2, 18'd3));
    append_instr(branch_word(BLT, 5'd1, 5'd2, 18'd2));
    append_instr(imm_word(ADDI, 5'd9, 5'd0, 18'd1)); // Squashed.
    append_instr(imm_word(ADDI, 5'd3, 5'd0, 18'd11));
    append_instr(branch_word(BGE, 5'd1, 5'd2, 18'd2));
    append_instr(branch_word(BNE, 5'd1, 5'd2, 18'd2));
    append_instr(imm_word(ADDI, 5'd9, 5'd0, 18'd2));
    append_instr(imm_word(ADDI, 5'd4, 5'd0, 18'd22));
    append_instr(branch_word(BGE, 5'd2, 5'd1, 18'd2));
    append_instr(imm_word(ADDI, 5'd9, 5'd0, 18'd3));
    append_instr(branch_word(BLT, 5'd2, 5'd1, 18'd2));
    append_instr(branch_word(BEQ, 5'd1, 5'd1, 18'd2));
    append_instr(imm_word(ADDI, 5'd9, 5'd0, 18'd4));
    append_instr(branch_word(BNE, 5'd1, 5'd1, 18'd2));
    append_instr(imm_word(ADDI, 5'd5, 5'd0, 18'd33));
    close_program();
    run_program("branch conditions");
  endtask

  task automatic bounded_jump_loop();
    prog_q.delete();
    append_instr(imm_word(ADDI, 5'd1, 5'd0, 18'd4));
    append_instr(imm_word(ADDI, 5'd2, 5'd0, 18'd0));
    append_instr(imm_word(ADDI, 5'd2, 5'd2, 18'd3)); // Loop top.
    append_instr(imm_word(ADDI, 5'd1, 5'd1, -18'sd1));
    append_instr(branch_word(BNE, 5'd1, 5'd0, 18'd2));
    append_instr(branch_word(JMP, 5'd0, 5'd0, 18'd3));
    append_instr(branch_word(JMP, 5'd0, 5'd0, -18'sd4));
    append_instr(imm_word(ADDI, 5'd9, 5'd0, 18'd9));
    append_instr(alu_word(ADD, 5'd3, 5'd2, 5'd1));
    close_program();
    run_program("jump loop");
  endtask

  task automatic random_alu_ops();
    logic [31:0] op_sel;
    logic [31:0] rd;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] imm;
    prog_q.delete();
    for (int i = 0; i < 20; i++) begin
      random_bits(3, op_sel);
      random_bits(3, rd);
      random_bits(3, ra);
      random_bits(3, rb);
      random_bits(18, imm);
      if (i == 10) begin
        rd = '0; // At least one write aimed at register 0.
      end
      if (op_sel >= 5) begin
        append_instr(imm_word(ADDI, rd[4:0], ra[4:0], imm[17:0]));
      end else begin
        append_instr(alu_word(opcode_e'(op_sel[3:0]), rd[4:0], ra[4:0], rb[4:0]));
      end
    end
    close_program();
    run_program("random ALU");
  endtask

  initial begin
    #(CLK_PERIOD * TEST_CYCLES * NUM_TESTS * MARGIN);
    abort_run("Watchdog expired before the tests finished.");
  end

  initial begin
    rst_i      = 1'b0;
    prog_we_i  = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    monitor_on = 1'b0;
    lfsr_state = 16'd39;
    chain_alu_ops();
    store_then_load();
    branch_conditions();
    bounded_jump_loop();
    random_alu_ops();
    $display("TEST OK");
    $finish;
  end

endmodule : tb_pipe3_cpu
